//--- src/dcache_cfg.svh
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// cache geometry, two ways
`define DCACHE_INDEX_W      6
`define DCACHE_WORD_OFF_W   4
`define DCACHE_BYTE_OFF_W   (`DCACHE_WORD_OFF_W + 2)
`define DCACHE_TAG_W        (32 - `DCACHE_BYTE_OFF_W - `DCACHE_INDEX_W)
`define DCACHE_LINE_BYTES   (1 << `DCACHE_BYTE_OFF_W)
`define DCACHE_LINE_BITS    (`DCACHE_LINE_BYTES * 8)

// a whole line moves in this many memory beats
`define DCACHE_REFILL_BEATS 1
`define DCACHE_BEAT_BITS    (`DCACHE_LINE_BITS / `DCACHE_REFILL_BEATS)

`endif

//--- src/dcache_req_pkg.sv
`default_nettype none

package dcache_req_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  wstrb_t;   // byte mask inside one word
    typedef logic [1:0]  acc_size_t;

    localparam acc_size_t SIZE_BYTE = 2'd0;
    localparam acc_size_t SIZE_HALF = 2'd1;
    localparam acc_size_t SIZE_WORD = 2'd2;

    // store data is right aligned, the byte lane comes from addr[1:0]
    typedef struct packed {
        logic      write;
        logic      signed_ext;  // loads only
        acc_size_t size;
        addr_t     addr;
        word_t     wdata;
    } dcache_req_t;

    // stores answer with data zero
    typedef struct packed {
        logic  write;
        word_t rdata;
    } dcache_resp_t;

endpackage

`default_nettype wire

//--- src/dcache_line_pkg.sv
`default_nettype none

package dcache_line_pkg;

`include "dcache_cfg.svh"

    typedef logic [`DCACHE_TAG_W-1:0]      tag_t;
    typedef logic [`DCACHE_INDEX_W-1:0]    index_t;
    typedef logic [`DCACHE_WORD_OFF_W-1:0] word_off_t;

    // one beat carries the full line
    typedef logic [`DCACHE_BEAT_BITS*`DCACHE_REFILL_BEATS-1:0] line_t;
    typedef logic [`DCACHE_LINE_BYTES-1:0]                    line_be_t;
    typedef logic [31-`DCACHE_BYTE_OFF_W:0]                   line_addr_t;

    typedef struct packed {
        line_addr_t addr;
    } mem_rd_req_t;

    typedef struct packed {
        line_addr_t addr;
        line_t      data;
    } mem_wr_req_t;

endpackage

`default_nettype wire

//--- src/dcache_way_ram.sv
`default_nettype none
`include "dcache_cfg.svh"

module dcache_way_ram
    import dcache_line_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rstn,
    input  wire index_t   i_rd_index,
    input  wire index_t   i_wr_index,
    input  wire line_be_t i_data_be,
    input  wire line_t    i_data,
    input  wire logic     i_tag_we,
    input  wire tag_t     i_tag,
    input  wire logic     i_dirty_we,
    input  wire logic     i_dirty,
    output line_t         o_data,
    output tag_t          o_tag,
    output logic          o_valid,
    output logic          o_dirty
);
    localparam int SETS = 1 << `DCACHE_INDEX_W;

    line_t           data_mem [SETS];
    tag_t            tag_mem  [SETS];
    logic [SETS-1:0] valid_q;
    logic [SETS-1:0] dirty_q;
    logic            same_set;

    // write first, a read of the set being written sees the new value
    assign same_set = (i_rd_index == i_wr_index);

    always_ff @(posedge clk) begin
        for (int b = 0; b < `DCACHE_LINE_BYTES; b++) begin
            if (i_data_be[b])
                data_mem[i_wr_index][b*8 +: 8] <= i_data[b*8 +: 8];
            o_data[b*8 +: 8] <= (i_data_be[b] && same_set) ? i_data[b*8 +: 8]
                                                           : data_mem[i_rd_index][b*8 +: 8];
        end
        if (i_tag_we)
            tag_mem[i_wr_index] <= i_tag;
        o_tag <= (i_tag_we && same_set) ? i_tag : tag_mem[i_rd_index];
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q <= '0;
            dirty_q <= '0;
            o_valid <= 1'b0;
            o_dirty <= 1'b0;
        end else begin
            if (i_tag_we)
                valid_q[i_wr_index] <= 1'b1;   // a tag write makes the line valid
            if (i_dirty_we)
                dirty_q[i_wr_index] <= i_dirty;
            o_valid <= (i_tag_we && same_set) | valid_q[i_rd_index];
            o_dirty <= (i_dirty_we && same_set) ? i_dirty : dirty_q[i_rd_index];
        end
    end

endmodule

`default_nettype wire

//--- src/dcache_data_align.sv
`default_nettype none
`include "dcache_cfg.svh"

module dcache_data_align
    import dcache_req_pkg::*;
    import dcache_line_pkg::*;
(
    input  wire dcache_req_t i_req,
    input  wire line_t       i_refill,
    input  wire logic        i_refill_sel,
    input  wire line_t       i_way_line,
    output line_t            o_wr_line,
    output line_be_t         o_wr_be,
    output word_t            o_rd_word
);
    localparam int WORDS = 1 << `DCACHE_WORD_OFF_W;

    word_off_t word_off;
    wstrb_t    wstrb;
    word_t     st_word;
    line_t     st_line;
    line_t     rd_line;
    word_t     rd_word;
    word_t     rd_shift;

    assign word_off = i_req.addr[`DCACHE_BYTE_OFF_W-1:2];

    // byte strobes of the store inside its word
    always_comb begin
        case (i_req.size)
            SIZE_BYTE: wstrb = 4'b0001 << i_req.addr[1:0];
            SIZE_HALF: wstrb = 4'b0011 << i_req.addr[1:0];
            default:   wstrb = 4'b1111;
        endcase
        if (!i_req.write)
            wstrb = '0;
    end

    assign st_word = i_req.wdata << {i_req.addr[1:0], 3'b000};  // move to its byte lane
    assign st_line = {WORDS{st_word}};                           // every word slot, be picks one
    assign o_wr_be = line_be_t'(wstrb) << {word_off, 2'b00};

    // store bytes over the refill line, only strobed bytes count on a hit
    always_comb begin
        for (int b = 0; b < `DCACHE_LINE_BYTES; b++)
            o_wr_line[b*8 +: 8] = o_wr_be[b] ? st_line[b*8 +: 8] : i_refill[b*8 +: 8];
    end

    assign rd_line  = i_refill_sel ? i_refill : i_way_line;
    assign rd_word  = rd_line[{word_off, 5'b00000} +: 32];
    assign rd_shift = rd_word >> {i_req.addr[1:0], 3'b000};

    always_comb begin
        case (i_req.size)
            SIZE_BYTE: o_rd_word = {{24{i_req.signed_ext & rd_shift[7]}}, rd_shift[7:0]};
            SIZE_HALF: o_rd_word = {{16{i_req.signed_ext & rd_shift[15]}}, rd_shift[15:0]};
            default:   o_rd_word = rd_word;
        endcase
    end

endmodule

`default_nettype wire

//--- src/dcache_writeback.sv
`default_nettype none

module dcache_writeback
    import dcache_line_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rstn,
    input  wire logic       i_start,
    input  wire logic       i_dirty,
    input  wire logic       i_way,
    input  wire line_addr_t i_addr,
    input  wire line_t      i_line0,
    input  wire line_t      i_line1,
    output logic            o_done,
    input  wire logic       i_clear,
    output logic            o_mem_wr_valid,
    output mem_wr_req_t     o_mem_wr,
    input  wire logic       i_mem_wr_ready
);
    typedef enum logic [1:0] {INIT, WRITE, FINISH} wb_state_e;

    wb_state_e  state_q;
    line_addr_t addr_q;
    line_t      line_q;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state_q <= INIT;
        end else begin
            case (state_q)
                INIT: begin
                    if (i_start)
                        state_q <= i_dirty ? WRITE : FINISH;
                end
                WRITE: begin
                    if (i_mem_wr_ready)
                        state_q <= FINISH;
                end
                FINISH: begin
                    if (i_clear)
                        state_q <= INIT;
                end
                default: state_q <= INIT;
            endcase
        end
    end

    // own copy of the victim, the refill may overwrite the array
    always_ff @(posedge clk) begin
        if (state_q == INIT && i_start) begin
            addr_q <= i_addr;
            line_q <= i_way ? i_line1 : i_line0;
        end
    end

    assign o_mem_wr_valid = (state_q == WRITE);
    assign o_mem_wr.addr  = addr_q;
    assign o_mem_wr.data  = line_q;
    assign o_done         = (state_q == FINISH);   // held until i_clear

endmodule

`default_nettype wire

//--- src/dcache_ctrl.sv
`default_nettype none
`include "dcache_cfg.svh"

module dcache_ctrl
    import dcache_req_pkg::*;
    import dcache_line_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rstn,
    input  wire logic        i_req_valid,
    input  wire dcache_req_t i_req,
    output logic             o_req_ready,
    output logic             o_resp_valid,
    output dcache_resp_t     o_resp,
    output dcache_req_t      o_buf_req,
    output index_t           o_rd_index,
    output index_t           o_wr_index,
    output line_be_t         o_data_be0,
    output line_be_t         o_data_be1,
    output logic [1:0]       o_tag_we,
    output tag_t             o_tag,
    output logic [1:0]       o_dirty_we,
    output logic             o_dirty,
    output logic             o_refill_sel,
    output logic             o_hit_way,
    input  wire tag_t        i_tag0,
    input  wire tag_t        i_tag1,
    input  wire logic [1:0]  i_valid,
    input  wire logic [1:0]  i_dirty,
    input  wire line_be_t    i_wr_be,
    input  wire word_t       i_rd_word,
    output logic             o_mem_rd_valid,
    output mem_rd_req_t      o_mem_rd,
    input  wire logic        i_mem_rd_ready,
    input  wire line_t       i_mem_rd_data,
    output line_t            o_refill_line,
    output logic             o_wb_start,
    output logic             o_wb_way,
    output line_addr_t       o_wb_addr,
    output logic             o_wb_dirty,
    input  wire logic        i_wb_done,
    output logic             o_wb_clear
);
    typedef enum logic [2:0] {IDLE, LOOKUP, MISS, REFILL, WAIT_WRITE} state_e;

    localparam int SETS = 1 << `DCACHE_INDEX_W;

    state_e          state_q;
    state_e          state_d;
    dcache_req_t     req_q;     // request buffer
    line_t           ret_q;     // return buffer, the refilled line
    logic [SETS-1:0] lru_q;     // way to replace next
    logic            lru_we;
    logic            lru_val;
    logic [1:0]      hit;
    logic            cache_hit;
    logic            victim;
    logic            accept;
    index_t          buf_index;
    tag_t            buf_tag;

    assign buf_index = req_q.addr[`DCACHE_BYTE_OFF_W +: `DCACHE_INDEX_W];
    assign buf_tag   = req_q.addr[31 -: `DCACHE_TAG_W];

    assign hit[0]    = i_valid[0] && (i_tag0 == buf_tag);
    assign hit[1]    = i_valid[1] && (i_tag1 == buf_tag);
    assign cache_hit = |hit;
    assign o_hit_way = hit[1];
    assign victim    = lru_q[buf_index];
    assign accept    = i_req_valid && o_req_ready;

    // next request reads storage while this one compares
    assign o_rd_index    = accept ? i_req.addr[`DCACHE_BYTE_OFF_W +: `DCACHE_INDEX_W] : buf_index;
    assign o_wr_index    = buf_index;
    assign o_tag         = buf_tag;
    assign o_buf_req     = req_q;
    assign o_refill_line = ret_q;
    assign o_refill_sel  = (state_q == REFILL) || (state_q == WAIT_WRITE);
    assign o_mem_rd.addr = req_q.addr[31:`DCACHE_BYTE_OFF_W];

    // victim info, sampled by the write engine on o_wb_start only
    assign o_wb_way   = victim;
    assign o_wb_addr  = {victim ? i_tag1 : i_tag0, buf_index};
    assign o_wb_dirty = i_valid[victim] && i_dirty[victim];

    assign o_resp.write = req_q.write;
    assign o_resp.rdata = req_q.write ? '0 : i_rd_word;

    always_comb begin
        state_d        = state_q;
        o_req_ready    = 1'b0;
        o_resp_valid   = 1'b0;
        o_data_be0     = '0;
        o_data_be1     = '0;
        o_tag_we       = 2'b00;
        o_dirty_we     = 2'b00;
        o_dirty        = 1'b0;
        o_mem_rd_valid = 1'b0;
        o_wb_start     = 1'b0;
        o_wb_clear     = 1'b0;
        lru_we         = 1'b0;
        lru_val        = 1'b0;
        case (state_q)
            IDLE: begin
                o_req_ready = 1'b1;
                if (i_req_valid)
                    state_d = LOOKUP;
            end
            LOOKUP: begin
                if (cache_hit) begin
                    o_req_ready  = 1'b1;
                    o_resp_valid = 1'b1;
                    lru_we       = 1'b1;
                    lru_val      = ~hit[1];   // point at the other way
                    if (req_q.write) begin
                        o_data_be0 = hit[0] ? i_wr_be : '0;
                        o_data_be1 = hit[1] ? i_wr_be : '0;
                        o_dirty_we = hit;
                        o_dirty    = 1'b1;
                    end
                    state_d = i_req_valid ? LOOKUP : IDLE;
                end else begin
                    o_wb_start = 1'b1;  // engine skips the write if clean
                    state_d    = MISS;
                end
            end
            MISS: begin
                o_mem_rd_valid = 1'b1;
                if (i_mem_rd_ready)
                    state_d = REFILL;
            end
            REFILL: begin
                // whole line, pending store already merged in
                o_data_be0 = victim ? '0 : '1;
                o_data_be1 = victim ? '1 : '0;
                o_tag_we   = victim ? 2'b10 : 2'b01;
                o_dirty_we = victim ? 2'b10 : 2'b01;
                o_dirty    = req_q.write;
                lru_we     = 1'b1;
                lru_val    = ~victim;
                state_d    = WAIT_WRITE;
            end
            WAIT_WRITE: begin
                if (i_wb_done) begin
                    o_req_ready  = 1'b1;
                    o_resp_valid = 1'b1;
                    o_wb_clear   = 1'b1;
                    state_d      = i_req_valid ? LOOKUP : IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state_q <= IDLE;
            lru_q   <= '0;
        end else begin
            state_q <= state_d;
            if (lru_we)
                lru_q[buf_index] <= lru_val;
        end
    end

    always_ff @(posedge clk) begin
        if (accept)
            req_q <= i_req;
        if (o_mem_rd_valid && i_mem_rd_ready)
            ret_q <= i_mem_rd_data;
    end

endmodule

`default_nettype wire

//--- src/dcache_top.sv
`default_nettype none

module dcache_top
    import dcache_req_pkg::*;
    import dcache_line_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rstn,
    input  wire logic        i_req_valid,
    input  wire dcache_req_t i_req,
    output logic             o_req_ready,
    output logic             o_resp_valid,
    output dcache_resp_t     o_resp,
    output logic             o_mem_rd_valid,
    output mem_rd_req_t      o_mem_rd,
    input  wire logic        i_mem_rd_ready,
    input  wire line_t       i_mem_rd_data,
    output logic             o_mem_wr_valid,
    output mem_wr_req_t      o_mem_wr,
    input  wire logic        i_mem_wr_ready
);
    dcache_req_t buf_req;
    index_t      rd_index;
    index_t      wr_index;
    line_be_t    data_be0;
    line_be_t    data_be1;
    line_be_t    wr_be;
    logic [1:0]  tag_we;
    logic [1:0]  dirty_we;
    tag_t        wr_tag;
    tag_t        tag0;
    tag_t        tag1;
    logic        wr_dirty;
    logic [1:0]  valid;
    logic [1:0]  dirty;
    logic        refill_sel;
    logic        hit_way;
    line_t       line0;
    line_t       line1;
    line_t       way_line;
    line_t       wr_line;
    line_t       refill_line;
    word_t       rd_word;
    logic        wb_start;
    logic        wb_way;
    logic        wb_dirty;
    logic        wb_done;
    logic        wb_clear;
    line_addr_t  wb_addr;

    assign way_line = hit_way ? line1 : line0;  // hit way feeds the load path

    dcache_way_ram u_way0 (
        .clk        (clk),          .rstn       (rstn),
        .i_rd_index (rd_index),     .i_wr_index (wr_index),
        .i_data_be  (data_be0),     .i_data     (wr_line),
        .i_tag_we   (tag_we[0]),    .i_tag      (wr_tag),
        .i_dirty_we (dirty_we[0]),  .i_dirty    (wr_dirty),
        .o_data     (line0),        .o_tag      (tag0),
        .o_valid    (valid[0]),     .o_dirty    (dirty[0])
    );

    dcache_way_ram u_way1 (
        .clk        (clk),          .rstn       (rstn),
        .i_rd_index (rd_index),     .i_wr_index (wr_index),
        .i_data_be  (data_be1),     .i_data     (wr_line),
        .i_tag_we   (tag_we[1]),    .i_tag      (wr_tag),
        .i_dirty_we (dirty_we[1]),  .i_dirty    (wr_dirty),
        .o_data     (line1),        .o_tag      (tag1),
        .o_valid    (valid[1]),     .o_dirty    (dirty[1])
    );

    dcache_data_align u_align (
        .i_req        (buf_req),
        .i_refill     (refill_line),
        .i_refill_sel (refill_sel),
        .i_way_line   (way_line),
        .o_wr_line    (wr_line),
        .o_wr_be      (wr_be),
        .o_rd_word    (rd_word)
    );

    dcache_ctrl u_ctrl (
        .clk            (clk),            .rstn           (rstn),
        .i_req_valid    (i_req_valid),    .i_req          (i_req),
        .o_req_ready    (o_req_ready),    .o_resp_valid   (o_resp_valid),
        .o_resp         (o_resp),         .o_buf_req      (buf_req),
        .o_rd_index     (rd_index),       .o_wr_index     (wr_index),
        .o_data_be0     (data_be0),       .o_data_be1     (data_be1),
        .o_tag_we       (tag_we),         .o_tag          (wr_tag),
        .o_dirty_we     (dirty_we),       .o_dirty        (wr_dirty),
        .o_refill_sel   (refill_sel),     .o_hit_way      (hit_way),
        .i_tag0         (tag0),           .i_tag1         (tag1),
        .i_valid        (valid),          .i_dirty        (dirty),
        .i_wr_be        (wr_be),          .i_rd_word      (rd_word),
        .o_mem_rd_valid (o_mem_rd_valid), .o_mem_rd       (o_mem_rd),
        .i_mem_rd_ready (i_mem_rd_ready), .i_mem_rd_data  (i_mem_rd_data),
        .o_refill_line  (refill_line),    .o_wb_start     (wb_start),
        .o_wb_way       (wb_way),         .o_wb_addr      (wb_addr),
        .o_wb_dirty     (wb_dirty),       .i_wb_done      (wb_done),
        .o_wb_clear     (wb_clear)
    );

    dcache_writeback u_wb (
        .clk            (clk),
        .rstn           (rstn),
        .i_start        (wb_start),
        .i_dirty        (wb_dirty),
        .i_way          (wb_way),
        .i_addr         (wb_addr),
        .i_line0        (line0),
        .i_line1        (line1),
        .o_done         (wb_done),
        .i_clear        (wb_clear),
        .o_mem_wr_valid (o_mem_wr_valid),
        .o_mem_wr       (o_mem_wr),
        .i_mem_wr_ready (i_mem_wr_ready)
    );

endmodule

`default_nettype wire

//--- tests/tb_mem_model.sv
`default_nettype none

module tb_mem_model
    import dcache_line_pkg::*;
#(
    parameter logic [31:0] SEED = 32'h0000_0001
) (
    input  wire logic        clk,
    input  wire logic        rstn,
    input  wire logic        i_rd_valid,
    input  wire mem_rd_req_t i_rd,
    output logic             o_rd_ready,
    output line_t            o_rd_data,
    input  wire logic        i_wr_valid,
    input  wire mem_wr_req_t i_wr,
    output logic             o_wr_ready
);
    localparam int WORDS  = $bits(line_t) / 32;
    localparam int WOFF_W = $clog2(WORDS);

    logic [31:0] words [logic [31:0]];   // sparse, keyed by word address
    integer      seed;
    int          rd_wait;
    int          wr_wait;

    // initial content, every address bit matters
    function automatic logic [31:0] addr_hash(input logic [31:0] addr);
        return (addr * 32'h9e3779b1) ^ (addr >> 11) ^ 32'h5bd1e995;
    endfunction

    function automatic line_t read_line(input line_addr_t la);
        line_t       line;
        logic [31:0] wa;
        for (int w = 0; w < WORDS; w++) begin
            wa = 32'({la, WOFF_W'(w)});
            line[w*32 +: 32] = words.exists(wa) ? words[wa] : addr_hash({wa[29:0], 2'b00});
        end
        return line;
    endfunction

    initial begin
        seed       = SEED;
        o_rd_ready = 1'b0;
        o_rd_data  = '0;
        o_wr_ready = 1'b0;
        rd_wait    = 0;
        wr_wait    = 0;
    end

    // both ports in one block so the random sequence has a fixed order
    always @(posedge clk) begin
        if (!rstn) begin
            o_rd_ready <= 1'b0;
            o_wr_ready <= 1'b0;
        end else begin
            if (o_rd_ready) begin
                o_rd_ready <= 1'b0;   // handshake on this edge
            end else if (i_rd_valid) begin
                if (rd_wait == 0) begin
                    o_rd_ready <= 1'b1;
                    o_rd_data  <= read_line(i_rd.addr);
                    rd_wait    <= $unsigned($random(seed)) % 4;
                end else begin
                    rd_wait <= rd_wait - 1;
                end
            end
            if (o_wr_ready) begin
                o_wr_ready <= 1'b0;
                for (int w = 0; w < WORDS; w++)
                    words[32'({i_wr.addr, WOFF_W'(w)})] = i_wr.data[w*32 +: 32];
            end else if (i_wr_valid) begin
                if (wr_wait == 0) begin
                    o_wr_ready <= 1'b1;
                    wr_wait    <= $unsigned($random(seed)) % 4;
                end else begin
                    wr_wait <= wr_wait - 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- tests/tb_dcache.sv
`default_nettype none

module tb_dcache
    import dcache_req_pkg::*;
    import dcache_line_pkg::*;
();
    localparam logic [31:0] SEED = 32'hcd84af9f;
    localparam int LINE_BYTES = $bits(line_t) / 8;
    localparam int OFF_W      = $clog2(LINE_BYTES);
    localparam int TIMEOUT    = 2000;

    typedef struct packed {
        logic        write;
        word_t       rdata;
        logic        must_hit;
        logic [31:0] cycle;   // negedge count at acceptance
    } expect_t;

    logic         clk;
    logic         rstn;
    logic         req_valid;
    dcache_req_t  req;
    logic         req_ready;
    logic         resp_valid;
    dcache_resp_t resp;
    logic         mem_rd_valid;
    mem_rd_req_t  mem_rd;
    logic         mem_rd_ready;
    line_t        mem_rd_data;
    logic         mem_wr_valid;
    mem_wr_req_t  mem_wr;
    logic         mem_wr_ready;

    logic [7:0]   model_mem [logic [31:0]];   // bytes written by stores
    logic         dirty_lines [line_addr_t];
    expect_t      exp_q [$];
    integer       seed;
    logic [31:0]  cycle;
    int           wr_count;
    logic         hit_flag;
    string        test_name;

    dcache_top u_dut (
        .clk            (clk),          .rstn           (rstn),
        .i_req_valid    (req_valid),    .i_req          (req),
        .o_req_ready    (req_ready),    .o_resp_valid   (resp_valid),
        .o_resp         (resp),         .o_mem_rd_valid (mem_rd_valid),
        .o_mem_rd       (mem_rd),       .i_mem_rd_ready (mem_rd_ready),
        .i_mem_rd_data  (mem_rd_data),  .o_mem_wr_valid (mem_wr_valid),
        .o_mem_wr       (mem_wr),       .i_mem_wr_ready (mem_wr_ready)
    );

    tb_mem_model #(.SEED(SEED)) u_mem (
        .clk        (clk),          .rstn       (rstn),
        .i_rd_valid (mem_rd_valid), .i_rd       (mem_rd),
        .o_rd_ready (mem_rd_ready), .o_rd_data  (mem_rd_data),
        .i_wr_valid (mem_wr_valid), .i_wr       (mem_wr),
        .o_wr_ready (mem_wr_ready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] addr_hash(input logic [31:0] addr);
        return (addr * 32'h9e3779b1) ^ (addr >> 11) ^ 32'h5bd1e995;
    endfunction

    function automatic logic [7:0] model_byte(input logic [31:0] addr);
        logic [31:0] word;
        word = addr_hash({addr[31:2], 2'b00});
        return model_mem.exists(addr) ? model_mem[addr] : word[addr[1:0]*8 +: 8];
    endfunction

    function automatic int size_bytes(input acc_size_t size);
        return (size == SIZE_BYTE) ? 1 : (size == SIZE_HALF) ? 2 : 4;
    endfunction

    function automatic word_t load_value(input dcache_req_t r);
        word_t v;
        int    n;
        n = size_bytes(r.size);
        v = '0;
        for (int b = 0; b < n; b++)
            v[b*8 +: 8] = model_byte(r.addr + b);
        if (r.signed_ext && v[n*8-1])
            for (int b = n; b < 4; b++)
                v[b*8 +: 8] = 8'hff;
        return v;
    endfunction

    function automatic line_t expected_line(input line_addr_t la);
        line_t line;
        for (int b = 0; b < LINE_BYTES; b++)
            line[b*8 +: 8] = model_byte({la, OFF_W'(b)});
        return line;
    endfunction

    function automatic dcache_req_t make_req(input logic write, input logic sext,
                                             input acc_size_t size, input addr_t addr,
                                             input word_t data);
        dcache_req_t r;
        r.write      = write;
        r.signed_ext = sext;
        r.size       = size;
        r.addr       = addr;
        r.wdata      = data;
        return r;
    endfunction

    function automatic string mismatch_text(input string what, input logic [31:0] exp,
                                            input logic [31:0] act);
        return $sformatf("mismatch %s (%s): expected %h actual %h", test_name, what, exp, act);
    endfunction

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1);
    endtask

    // drive at posedge and return at the negedge before the accepting edge
    task automatic send_req(input dcache_req_t r, input logic must_hit);
        int waited;
        waited = 0;
        @(posedge clk);
        req_valid <= 1'b1;
        req       <= r;
        hit_flag  <= must_hit;
        @(negedge clk);
        while (!req_ready) begin
            waited++;
            if (waited > TIMEOUT)
                stop_with_error("request was not accepted before the timeout");
            @(negedge clk);
        end
    endtask

    task automatic release_bus();
        @(posedge clk);
        req_valid <= 1'b0;
    endtask

    task automatic wait_responses();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            waited++;
            if (waited > TIMEOUT)
                stop_with_error("a response did not arrive before the timeout");
            @(posedge clk);
        end
    endtask

    // responses, memory writes and acceptances sampled at negedge
    always @(negedge clk) begin : monitor
        expect_t e;
        cycle = cycle + 1;
        if (rstn) begin
            if (resp_valid) begin
                assert (exp_q.size() > 0)
                    else stop_with_error("response without an outstanding request");
                e = exp_q.pop_front();
                assert (resp.write == e.write)
                    else stop_with_error(mismatch_text("resp write", e.write, resp.write));
                assert (resp.rdata == e.rdata)
                    else stop_with_error(mismatch_text("resp data", e.rdata, resp.rdata));
                if (e.must_hit)
                    assert (cycle == e.cycle + 1)
                        else stop_with_error(mismatch_text("hit latency", e.cycle + 1, cycle));
            end
            if (mem_wr_valid && mem_wr_ready) begin
                wr_count++;
                assert (dirty_lines.exists(mem_wr.addr))
                    else stop_with_error($sformatf("memory write to clean line %h", mem_wr.addr));
                assert (mem_wr.data == expected_line(mem_wr.addr))
                    else stop_with_error($sformatf("mismatch %s (victim %h): expected %h actual %h",
                                                   test_name, mem_wr.addr,
                                                   expected_line(mem_wr.addr), mem_wr.data));
                dirty_lines.delete(mem_wr.addr);
            end
            if (req_valid && req_ready) begin
                e.write    = req.write;
                e.rdata    = req.write ? '0 : load_value(req);
                e.must_hit = hit_flag;
                e.cycle    = cycle;
                exp_q.push_back(e);
                if (req.write) begin
                    for (int n = 0; n < size_bytes(req.size); n++)
                        model_mem[req.addr + n] = req.wdata[n*8 +: 8];
                    dirty_lines[req.addr[31:OFF_W]] = 1'b1;
                end
            end
        end
    end

    initial begin
        addr_t     base;
        addr_t     addr;
        addr_t     lines [3];
        tag_t      tags [4];
        word_t     pattern [2];
        acc_size_t size;
        logic      wr;
        logic      sext;
        word_t     data;
        int        wr_start;
        seed      = SEED;
        cycle     = '0;
        wr_count  = 0;
        rstn      = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        hit_flag  = 1'b0;
        test_name = "reset";
        repeat (16) @(posedge clk);
        rstn <= 1'b1;

        repeat (4) begin
            @(negedge clk);
            assert (req_ready === 1'b1) else stop_with_error("ready is low after reset");
            assert ({resp_valid, mem_rd_valid, mem_wr_valid} === 3'b000)
                else stop_with_error("a valid output is high after reset");
        end

        // prime one line and hit it back to back
        test_name = "store then load";
        base = {tag_t'($random(seed)), index_t'(1), word_off_t'($random(seed)), 2'b00};
        send_req(make_req(1'b0, 1'b0, SIZE_WORD, base, '0), 1'b0);
        release_bus();
        wait_responses();
        data = $random(seed);
        send_req(make_req(1'b1, 1'b0, SIZE_BYTE, base + 1, data), 1'b1);
        data = $random(seed);
        send_req(make_req(1'b1, 1'b0, SIZE_HALF, base + 2, data), 1'b1);
        send_req(make_req(1'b0, 1'b0, SIZE_WORD, base, '0), 1'b1);
        data = $random(seed);
        send_req(make_req(1'b1, 1'b0, SIZE_WORD, base ^ 32'h4, data), 1'b1);
        send_req(make_req(1'b0, 1'b0, SIZE_WORD, base ^ 32'h4, '0), 1'b1);
        send_req(make_req(1'b0, 1'b1, SIZE_HALF, base + 2, '0), 1'b1);
        release_bus();
        wait_responses();

        test_name = "sub-word loads";
        pattern[0] = $random(seed);
        pattern[1] = 32'h8001_7fff;   // both sign bit values in bytes and halves
        for (int p = 0; p < 2; p++) begin
            base = {tag_t'($random(seed)), index_t'(2), word_off_t'($random(seed)), 2'b00};
            send_req(make_req(1'b1, 1'b0, SIZE_WORD, base, pattern[p]), 1'b0);
            for (int off = 0; off < 4; off++) begin
                send_req(make_req(1'b0, 1'b0, SIZE_BYTE, base + off, '0), 1'b1);
                send_req(make_req(1'b0, 1'b1, SIZE_BYTE, base + off, '0), 1'b1);
            end
            for (int off = 0; off < 4; off += 2) begin
                send_req(make_req(1'b0, 1'b0, SIZE_HALF, base + off, '0), 1'b1);
                send_req(make_req(1'b0, 1'b1, SIZE_HALF, base + off, '0), 1'b1);
            end
            release_bus();
            wait_responses();
        end

        // three lines in set 5 with two of them dirty
        test_name = "eviction";
        tags[0] = $random(seed);
        for (int k = 0; k < 3; k++)
            lines[k] = {tag_t'(tags[0] + k), index_t'(5), word_off_t'(k), 2'b00};
        wr_start = wr_count;
        data = $random(seed);
        send_req(make_req(1'b1, 1'b0, SIZE_WORD, lines[0], data), 1'b0);
        data = $random(seed);
        send_req(make_req(1'b1, 1'b0, SIZE_WORD, lines[1], data), 1'b0);
        send_req(make_req(1'b0, 1'b0, SIZE_WORD, lines[2], '0), 1'b0);
        release_bus();
        wait_responses();
        assert (wr_count == wr_start + 1)
            else stop_with_error(mismatch_text("memory writes", wr_start + 1, wr_count));
        send_req(make_req(1'b0, 1'b0, SIZE_WORD, lines[0], '0), 1'b0);
        release_bus();
        wait_responses();
        assert (wr_count == wr_start + 2)
            else stop_with_error(mismatch_text("memory writes", wr_start + 2, wr_count));
        send_req(make_req(1'b0, 1'b0, SIZE_WORD, lines[1], '0), 1'b0);  // clean victim
        send_req(make_req(1'b0, 1'b0, SIZE_WORD, lines[0], '0), 1'b1);
        release_bus();
        wait_responses();
        assert (wr_count == wr_start + 2)
            else stop_with_error(mismatch_text("memory writes", wr_start + 2, wr_count));

        test_name = "random mix";
        for (int k = 0; k < 4; k++)
            tags[k] = $random(seed);
        for (int n = 0; n < 400; n++) begin
            size = acc_size_t'($unsigned($random(seed)) % 3);
            base = {tags[$unsigned($random(seed)) % 4], 12'h0};
            addr = {base[31:12], index_t'(8 + $unsigned($random(seed)) % 3),
                    word_off_t'($random(seed)), 2'b00};
            if (size == SIZE_BYTE)
                addr[1:0] = 2'($random(seed));
            else if (size == SIZE_HALF)
                addr[1] = 1'($random(seed));
            wr   = 1'($random(seed));
            sext = 1'($random(seed));
            data = $random(seed);
            send_req(make_req(wr, sext, size, addr, data), 1'b0);
            if (($random(seed) & 3) == 0)
                release_bus();   // an idle gap now and then
        end
        release_bus();
        wait_responses();

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- dcache.f
+incdir+src
src/dcache_req_pkg.sv
src/dcache_line_pkg.sv
src/dcache_way_ram.sv
src/dcache_data_align.sv
src/dcache_writeback.sv
src/dcache_ctrl.sv
src/dcache_top.sv
tests/tb_mem_model.sv
tests/tb_dcache.sv
